/* src/rv_exec_pkg.sv */
package rv_exec_pkg;

    localparam int XLEN      = 64;
    localparam int DIV_STEPS = 64;   // one quotient bit per step

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      alu_op_t;
    typedef logic [2:0]      ext_sel_t;

    // opcodes
    localparam alu_op_t OP_ADD  = 5'd0;
    localparam alu_op_t OP_SUB  = 5'd1;
    localparam alu_op_t OP_SLL  = 5'd2;
    localparam alu_op_t OP_SRL  = 5'd3;
    localparam alu_op_t OP_SRA  = 5'd4;
    localparam alu_op_t OP_AND  = 5'd5;
    localparam alu_op_t OP_OR   = 5'd6;
    localparam alu_op_t OP_XOR  = 5'd7;
    localparam alu_op_t OP_SLT  = 5'd8;
    localparam alu_op_t OP_SLTU = 5'd9;
    localparam alu_op_t OP_MUL  = 5'd10;  // low half only
    localparam alu_op_t OP_DIVU = 5'd11;
    localparam alu_op_t OP_REMU = 5'd12;
    localparam alu_op_t OP_PASS = 5'd13;  // src2 through, load data
    localparam alu_op_t OP_BEQ  = 5'd14;
    localparam alu_op_t OP_BNE  = 5'd15;
    localparam alu_op_t OP_BLT  = 5'd16;
    localparam alu_op_t OP_BGE  = 5'd17;
    localparam alu_op_t OP_BLTU = 5'd18;
    localparam alu_op_t OP_BGEU = 5'd19;

    // result extension
    localparam ext_sel_t EXT_NONE = 3'd0;
    localparam ext_sel_t EXT_SW   = 3'd1;  // from bit 31
    localparam ext_sel_t EXT_ZW   = 3'd2;  // low word, zero filled
    localparam ext_sel_t EXT_SH   = 3'd3;  // from bit 15
    localparam ext_sel_t EXT_SB   = 3'd4;  // from bit 7

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_DIV,
        LANE_DONE
    } lane_state_t;

endpackage

/* src/alu_issue_dispatch.sv */
`timescale 1ns/100ps

module alu_issue_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  op_req,
    output logic                  op_ack,
    input  rv_exec_pkg::alu_op_t  op_code,
    input  logic                  word_op,
    input  rv_exec_pkg::ext_sel_t ext_sel,
    input  rv_exec_pkg::xlen_t    src1,
    input  rv_exec_pkg::xlen_t    src2,
    input  logic [NUM_LANES-1:0]  lane_done,
    output logic [NUM_LANES-1:0]  lane_issue,
    output rv_exec_pkg::alu_op_t  issue_op,
    output logic                  issue_word,
    output rv_exec_pkg::ext_sel_t issue_ext,
    output rv_exec_pkg::xlen_t    issue_src1,
    output rv_exec_pkg::xlen_t    issue_src2
);

    localparam int PTR_W = $clog2(NUM_LANES);

    logic [PTR_W-1:0]     next_lane;  // round-robin pointer
    logic [NUM_LANES-1:0] busy;
    logic [NUM_LANES-1:0] done_q;     // for falling edge of lane_done
    logic                 take;

    assign take = op_req && !op_ack && !busy[next_lane];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_ack     <= 1'b0;
            lane_issue <= '0;
            next_lane  <= '0;
        end else begin
            lane_issue <= '0;
            if (take) begin
                op_ack                <= 1'b1;
                lane_issue[next_lane] <= 1'b1;
                if (next_lane == PTR_W'(NUM_LANES - 1)) begin
                    next_lane <= '0;
                end else begin
                    next_lane <= next_lane + 1'b1;
                end
            end else if (!op_req) begin
                op_ack <= 1'b0;  // return to zero
            end
        end
    end

    // lane stays busy from issue until its done drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= '0;
            done_q <= '0;
        end else begin
            done_q <= lane_done;
            for (int i = 0; i < NUM_LANES; i++) begin
                if (take && next_lane == PTR_W'(i)) begin
                    busy[i] <= 1'b1;
                end else if (done_q[i] && !lane_done[i]) begin
                    busy[i] <= 1'b0;
                end
            end
        end
    end

    // shared operand bus, valid with the issue pulse
    always_ff @(posedge clk) begin
        if (take) begin
            issue_op   <= op_code;
            issue_word <= word_op;
            issue_ext  <= ext_sel;
            issue_src1 <= src1;
            issue_src2 <= src2;
        end
    end

endmodule

/* src/alu_lane.sv */
`timescale 1ns/100ps

module alu_lane (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue,
    input  logic                  release_lane,
    input  rv_exec_pkg::alu_op_t  issue_op,
    input  logic                  issue_word,
    input  rv_exec_pkg::ext_sel_t issue_ext,
    input  rv_exec_pkg::xlen_t    issue_src1,
    input  rv_exec_pkg::xlen_t    issue_src2,
    output logic                  lane_done,
    output logic                  lane_flag,
    output rv_exec_pkg::xlen_t    lane_value
);

    localparam int XLEN  = rv_exec_pkg::XLEN;
    localparam int CNT_W = $clog2(rv_exec_pkg::DIV_STEPS);

    rv_exec_pkg::lane_state_t state;

    logic [5:0]               shamt;
    rv_exec_pkg::xlen_t       shr_src;
    rv_exec_pkg::xlen_t       sra_src;
    rv_exec_pkg::xlen_t       comb_value;
    logic                     comb_flag;
    logic                     start_div;

    rv_exec_pkg::xlen_t       div_quot;   // dividend shifts out, quotient in
    rv_exec_pkg::xlen_t       div_rem;
    rv_exec_pkg::xlen_t       div_den;
    logic [CNT_W-1:0]         div_cnt;
    logic                     div_is_rem;
    logic                     div_word;
    rv_exec_pkg::ext_sel_t    div_ext;
    logic [XLEN:0]            div_shift;
    logic [XLEN:0]            div_diff;
    rv_exec_pkg::xlen_t       quot_next;
    rv_exec_pkg::xlen_t       rem_next;

    function automatic rv_exec_pkg::xlen_t sext32(input rv_exec_pkg::xlen_t x);
        return {{32{x[31]}}, x[31:0]};
    endfunction

    // word handling first, then the extension select
    function automatic rv_exec_pkg::xlen_t shape(input rv_exec_pkg::xlen_t x,
                                                 input logic word,
                                                 input rv_exec_pkg::ext_sel_t ext);
        rv_exec_pkg::xlen_t w;
        w = word ? sext32(x) : x;
        case (ext)
            rv_exec_pkg::EXT_SW: return sext32(w);
            rv_exec_pkg::EXT_ZW: return {32'b0, w[31:0]};
            rv_exec_pkg::EXT_SH: return {{48{w[15]}}, w[15:0]};
            rv_exec_pkg::EXT_SB: return {{56{w[7]}}, w[7:0]};
            default:             return w;
        endcase
    endfunction

    assign start_div = (issue_op == rv_exec_pkg::OP_DIVU) || (issue_op == rv_exec_pkg::OP_REMU);

    always_comb begin
        shamt      = issue_word ? {1'b0, issue_src2[4:0]} : issue_src2[5:0];
        shr_src    = issue_word ? {32'b0, issue_src1[31:0]} : issue_src1;
        sra_src    = issue_word ? sext32(issue_src1) : issue_src1;
        comb_value = '0;
        comb_flag  = 1'b0;
        case (issue_op)
            rv_exec_pkg::OP_ADD:  comb_value = issue_src1 + issue_src2;
            rv_exec_pkg::OP_SUB:  comb_value = issue_src1 - issue_src2;
            rv_exec_pkg::OP_SLL:  comb_value = issue_src1 << shamt;
            rv_exec_pkg::OP_SRL:  comb_value = shr_src >> shamt;
            rv_exec_pkg::OP_SRA:  comb_value = $signed(sra_src) >>> shamt;
            rv_exec_pkg::OP_AND:  comb_value = issue_src1 & issue_src2;
            rv_exec_pkg::OP_OR:   comb_value = issue_src1 | issue_src2;
            rv_exec_pkg::OP_XOR:  comb_value = issue_src1 ^ issue_src2;
            rv_exec_pkg::OP_SLT:
                comb_value = rv_exec_pkg::xlen_t'($signed(issue_src1) < $signed(issue_src2));
            rv_exec_pkg::OP_SLTU: comb_value = rv_exec_pkg::xlen_t'(issue_src1 < issue_src2);
            rv_exec_pkg::OP_MUL:  comb_value = issue_src1 * issue_src2;
            rv_exec_pkg::OP_PASS: comb_value = issue_src2;
            rv_exec_pkg::OP_BEQ:  comb_flag = issue_src1 == issue_src2;
            rv_exec_pkg::OP_BNE:  comb_flag = issue_src1 != issue_src2;
            rv_exec_pkg::OP_BLT:  comb_flag = $signed(issue_src1) < $signed(issue_src2);
            rv_exec_pkg::OP_BGE:  comb_flag = $signed(issue_src1) >= $signed(issue_src2);
            rv_exec_pkg::OP_BLTU: comb_flag = issue_src1 < issue_src2;
            rv_exec_pkg::OP_BGEU: comb_flag = issue_src1 >= issue_src2;
            default:              comb_value = '0;  // divide handled below
        endcase
    end

    // restoring step; a zero divisor yields all ones and the dividend
    assign div_shift = {div_rem, div_quot[XLEN-1]};
    assign div_diff  = div_shift - {1'b0, div_den};
    assign quot_next = {div_quot[XLEN-2:0], !div_diff[XLEN]};
    assign rem_next  = div_diff[XLEN] ? div_shift[XLEN-1:0] : div_diff[XLEN-1:0];

    assign lane_done = (state == rv_exec_pkg::LANE_DONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= rv_exec_pkg::LANE_IDLE;
        end else begin
            case (state)
                rv_exec_pkg::LANE_IDLE:
                    if (issue) begin
                        state <= start_div ? rv_exec_pkg::LANE_DIV : rv_exec_pkg::LANE_DONE;
                    end
                rv_exec_pkg::LANE_DIV:
                    if (div_cnt == CNT_W'(rv_exec_pkg::DIV_STEPS - 1)) begin
                        state <= rv_exec_pkg::LANE_DONE;
                    end
                rv_exec_pkg::LANE_DONE:
                    if (release_lane) begin
                        state <= rv_exec_pkg::LANE_IDLE;
                    end
                default: state <= rv_exec_pkg::LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rv_exec_pkg::LANE_IDLE && issue) begin
            lane_value <= shape(comb_value, issue_word, issue_ext);
            lane_flag  <= comb_flag;
            div_quot   <= issue_word ? {32'b0, issue_src1[31:0]} : issue_src1;
            div_den    <= issue_word ? {32'b0, issue_src2[31:0]} : issue_src2;
            div_rem    <= '0;
            div_cnt    <= '0;
            div_is_rem <= issue_op == rv_exec_pkg::OP_REMU;
            div_word   <= issue_word;
            div_ext    <= issue_ext;
        end else if (state == rv_exec_pkg::LANE_DIV) begin
            div_quot   <= quot_next;
            div_rem    <= rem_next;
            div_cnt    <= div_cnt + 1'b1;
            lane_value <= shape(div_is_rem ? rem_next : quot_next, div_word, div_ext);
        end
    end

endmodule

/* src/result_reorder.sv */
`timescale 1ns/100ps

module result_reorder #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 res_req,
    input  logic                 res_ack,
    output rv_exec_pkg::xlen_t   res_value,
    output logic                 res_flag,
    input  logic [NUM_LANES-1:0] lane_done,
    input  rv_exec_pkg::xlen_t   lane_value [NUM_LANES],
    input  logic                 lane_flag [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_release
);

    localparam int PTR_W = $clog2(NUM_LANES);

    typedef enum logic [1:0] {
        RO_WAIT,  // head lane not done yet
        RO_REQ,   // res_req up, waiting for ack
        RO_ACK    // waiting for ack to drop
    } ro_state_t;

    ro_state_t        state;
    logic [PTR_W-1:0] head;
    logic             load;

    assign load = (state == RO_WAIT) && lane_done[head] && !res_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= RO_WAIT;
            res_req      <= 1'b0;
            head         <= '0;
            lane_release <= '0;
        end else begin
            lane_release <= '0;
            case (state)
                RO_WAIT:
                    if (load) begin
                        res_req <= 1'b1;
                        state   <= RO_REQ;
                    end
                RO_REQ:
                    if (res_ack) begin
                        res_req <= 1'b0;
                        state   <= RO_ACK;
                    end
                RO_ACK:
                    if (!res_ack) begin
                        lane_release[head] <= 1'b1;  // frees the lane
                        state              <= RO_WAIT;
                        if (head == PTR_W'(NUM_LANES - 1)) begin
                            head <= '0;
                        end else begin
                            head <= head + 1'b1;
                        end
                    end
                default: state <= RO_WAIT;
            endcase
        end
    end

    // held stable while res_req is high
    always_ff @(posedge clk) begin
        if (load) begin
            res_value <= lane_value[head];
            res_flag  <= lane_flag[head];
        end
    end

endmodule

/* src/alu_cluster_top.sv */
`timescale 1ns/100ps

module alu_cluster_top #(
    parameter int NUM_LANES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  op_req,
    output logic                  op_ack,
    input  rv_exec_pkg::alu_op_t  op_code,
    input  logic                  word_op,
    input  rv_exec_pkg::ext_sel_t ext_sel,
    input  rv_exec_pkg::xlen_t    src1,
    input  rv_exec_pkg::xlen_t    src2,
    output logic                  res_req,
    input  logic                  res_ack,
    output rv_exec_pkg::xlen_t    res_value,
    output logic                  res_flag
);

    logic [NUM_LANES-1:0]  lane_issue;
    logic [NUM_LANES-1:0]  lane_release;
    logic [NUM_LANES-1:0]  lane_done;
    rv_exec_pkg::xlen_t    lane_value [NUM_LANES];
    logic                  lane_flag [NUM_LANES];
    rv_exec_pkg::alu_op_t  issue_op;
    logic                  issue_word;
    rv_exec_pkg::ext_sel_t issue_ext;
    rv_exec_pkg::xlen_t    issue_src1;
    rv_exec_pkg::xlen_t    issue_src2;

    alu_issue_dispatch #(
        .NUM_LANES(NUM_LANES)
    ) u_dispatch (
        .clk(clk), .rst_n(rst_n),
        .op_req(op_req), .op_ack(op_ack), .op_code(op_code), .word_op(word_op),
        .ext_sel(ext_sel), .src1(src1), .src2(src2),
        .lane_done(lane_done), .lane_issue(lane_issue),
        .issue_op(issue_op), .issue_word(issue_word), .issue_ext(issue_ext),
        .issue_src1(issue_src1), .issue_src2(issue_src2)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane u_lane (
            .clk(clk), .rst_n(rst_n),
            .issue(lane_issue[i]), .release_lane(lane_release[i]),
            .issue_op(issue_op), .issue_word(issue_word), .issue_ext(issue_ext),
            .issue_src1(issue_src1), .issue_src2(issue_src2),
            .lane_done(lane_done[i]), .lane_flag(lane_flag[i]), .lane_value(lane_value[i])
        );
    end

    result_reorder #(
        .NUM_LANES(NUM_LANES)
    ) u_reorder (
        .clk(clk), .rst_n(rst_n),
        .res_req(res_req), .res_ack(res_ack), .res_value(res_value), .res_flag(res_flag),
        .lane_done(lane_done), .lane_value(lane_value), .lane_flag(lane_flag),
        .lane_release(lane_release)
    );

endmodule

/* include/alu_ref_model.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// expected value of one operation
function automatic rv_exec_pkg::xlen_t ref_value(input rv_exec_pkg::alu_op_t op,
                                                 input logic word,
                                                 input rv_exec_pkg::ext_sel_t ext,
                                                 input rv_exec_pkg::xlen_t a,
                                                 input rv_exec_pkg::xlen_t b);
    rv_exec_pkg::xlen_t r;
    rv_exec_pkg::xlen_t da;
    rv_exec_pkg::xlen_t db;
    int unsigned        sh;
    sh = word ? b[4:0] : b[5:0];
    da = word ? {32'b0, a[31:0]} : a;
    db = word ? {32'b0, b[31:0]} : b;
    case (op)
        rv_exec_pkg::OP_ADD:  r = a + b;
        rv_exec_pkg::OP_SUB:  r = a - b;
        rv_exec_pkg::OP_SLL:  r = a << sh;
        rv_exec_pkg::OP_SRL:  r = da >> sh;
        rv_exec_pkg::OP_SRA:  r = $signed(word ? {{32{a[31]}}, a[31:0]} : a) >>> sh;
        rv_exec_pkg::OP_AND:  r = a & b;
        rv_exec_pkg::OP_OR:   r = a | b;
        rv_exec_pkg::OP_XOR:  r = a ^ b;
        rv_exec_pkg::OP_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        rv_exec_pkg::OP_SLTU: r = (a < b) ? 64'd1 : 64'd0;
        rv_exec_pkg::OP_MUL:  r = a * b;
        rv_exec_pkg::OP_DIVU: r = (db == 0) ? '1 : da / db;
        rv_exec_pkg::OP_REMU: r = (db == 0) ? da : da % db;
        rv_exec_pkg::OP_PASS: r = b;
        default:              r = '0;  // compares carry no value
    endcase
    if (word) begin
        r = {{32{r[31]}}, r[31:0]};
    end
    case (ext)
        rv_exec_pkg::EXT_SW: r = {{32{r[31]}}, r[31:0]};
        rv_exec_pkg::EXT_ZW: r = {32'b0, r[31:0]};
        rv_exec_pkg::EXT_SH: r = {{48{r[15]}}, r[15:0]};
        rv_exec_pkg::EXT_SB: r = {{56{r[7]}}, r[7:0]};
        default:             r = r;
    endcase
    return r;
endfunction

// branch taken flag, zero for everything else
function automatic logic ref_flag(input rv_exec_pkg::alu_op_t op,
                                  input rv_exec_pkg::xlen_t a,
                                  input rv_exec_pkg::xlen_t b);
    case (op)
        rv_exec_pkg::OP_BEQ:  return a == b;
        rv_exec_pkg::OP_BNE:  return a != b;
        rv_exec_pkg::OP_BLT:  return $signed(a) < $signed(b);
        rv_exec_pkg::OP_BGE:  return $signed(a) >= $signed(b);
        rv_exec_pkg::OP_BLTU: return a < b;
        rv_exec_pkg::OP_BGEU: return a >= b;
        default:              return 1'b0;
    endcase
endfunction

`endif

/* tests/tb_alu_cluster.sv */
`timescale 1ns/100ps

module tb_alu_cluster;

    localparam int NUM_LANES = 4;
    localparam int TIMEOUT   = 300;  // cycles allowed per wait

    logic                  clk;
    logic                  rst_n;
    logic                  op_req;
    logic                  op_ack;
    rv_exec_pkg::alu_op_t  op_code;
    logic                  word_op;
    rv_exec_pkg::ext_sel_t ext_sel;
    rv_exec_pkg::xlen_t    src1;
    rv_exec_pkg::xlen_t    src2;
    logic                  res_req;
    logic                  res_ack;
    rv_exec_pkg::xlen_t    res_value;
    logic                  res_flag;
    logic [15:0]           lfsr;

    `include "alu_ref_model.svh"

    alu_cluster_top #(
        .NUM_LANES(NUM_LANES)
    ) u_dut (
        .clk(clk), .rst_n(rst_n),
        .op_req(op_req), .op_ack(op_ack), .op_code(op_code), .word_op(word_op),
        .ext_sel(ext_sel), .src1(src1), .src2(src2),
        .res_req(res_req), .res_ack(res_ack), .res_value(res_value), .res_flag(res_flag)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test, input rv_exec_pkg::xlen_t exp,
                               input rv_exec_pkg::xlen_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", test, exp, act);
            abort_run("result value differs from the model");
        end
    endtask

    task automatic check_flag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", test, exp, act);
            abort_run("branch flag differs from the model");
        end
    endtask

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic rv_exec_pkg::xlen_t rand_bits(input int n);
        rv_exec_pkg::xlen_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic raise_op(input rv_exec_pkg::alu_op_t op, input logic word,
                            input rv_exec_pkg::ext_sel_t ext,
                            input rv_exec_pkg::xlen_t a, input rv_exec_pkg::xlen_t b);
        @(posedge clk);
        op_req  <= 1'b1;
        op_code <= op;
        word_op <= word;
        ext_sel <= ext;
        src1    <= a;
        src2    <= b;
    endtask

    task automatic wait_op_ack();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("no op_ack after timeout");
        end while (!op_ack);
    endtask

    task automatic finish_op();
        int n;
        n = 0;
        op_req <= 1'b0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("op_ack stuck high after op_req fell");
        end while (op_ack);
    endtask

    task automatic send_op(input rv_exec_pkg::alu_op_t op, input logic word,
                           input rv_exec_pkg::ext_sel_t ext,
                           input rv_exec_pkg::xlen_t a, input rv_exec_pkg::xlen_t b);
        raise_op(op, word, ext, a, b);
        wait_op_ack();
        finish_op();
    endtask

    task automatic take_result(output rv_exec_pkg::xlen_t value, output logic flag,
                               output int waited);
        int n;
        waited = 0;
        n      = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("no result after timeout");
        end while (!res_req);
        value   = res_value;   // held while res_req is high
        flag    = res_flag;
        res_ack <= 1'b1;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("res_req stuck high after res_ack rose");
        end while (res_req);
        res_ack <= 1'b0;
    endtask

    task automatic run_one(input string test, input rv_exec_pkg::alu_op_t op, input logic word,
                           input rv_exec_pkg::ext_sel_t ext, input rv_exec_pkg::xlen_t a,
                           input rv_exec_pkg::xlen_t b, output int waited);
        rv_exec_pkg::xlen_t value;
        logic               flag;
        send_op(op, word, ext, a, b);
        take_result(value, flag, waited);
        check_value(test, ref_value(op, word, ext, a, b), value);
        check_flag(test, ref_flag(op, a, b), flag);
    endtask

    task automatic exercise_alu_ops();
        rv_exec_pkg::alu_op_t ops [9];
        int                   waited;
        ops = '{rv_exec_pkg::OP_ADD, rv_exec_pkg::OP_SUB, rv_exec_pkg::OP_AND,
                rv_exec_pkg::OP_OR, rv_exec_pkg::OP_XOR, rv_exec_pkg::OP_MUL,
                rv_exec_pkg::OP_SLT, rv_exec_pkg::OP_SLTU, rv_exec_pkg::OP_PASS};
        for (int i = 0; i < 9; i++) begin
            for (int w = 0; w < 2; w++) begin
                for (int e = 0; e < 5; e++) begin
                    run_one($sformatf("alu op%0d w%0d e%0d", ops[i], w, e), ops[i], 1'(w),
                            rv_exec_pkg::ext_sel_t'(e), rand_bits(64), rand_bits(64), waited);
                end
            end
        end
    endtask

    task automatic sweep_shifts();
        rv_exec_pkg::alu_op_t ops [3];
        int                   amts [4];
        int                   waited;
        ops  = '{rv_exec_pkg::OP_SLL, rv_exec_pkg::OP_SRL, rv_exec_pkg::OP_SRA};
        amts = '{0, 31, 32, 63};
        for (int i = 0; i < 3; i++) begin
            for (int k = 0; k < 4; k++) begin
                for (int w = 0; w < 2; w++) begin
                    // upper src2 bits set so the amount mask matters
                    run_one($sformatf("shift op%0d amt%0d w%0d", ops[i], amts[k], w), ops[i],
                            1'(w), rv_exec_pkg::EXT_NONE, 64'hc3a5_0f1e_8765_4321,
                            64'h0000_1200_0000_0000 | 64'(amts[k]), waited);
                end
            end
        end
    endtask

    task automatic compare_branches();
        rv_exec_pkg::xlen_t a_set [3];
        rv_exec_pkg::xlen_t b_set [3];
        int                 waited;
        a_set = '{64'd5, 64'hffff_ffff_ffff_fffb, 64'd3};   // equal, signed less, unsigned less
        b_set = '{64'd5, 64'd3, 64'h8000_0000_0000_0000};
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 3; p++) begin
                run_one($sformatf("branch op%0d pair%0d", rv_exec_pkg::OP_BEQ + k, p),
                        rv_exec_pkg::OP_BEQ + 5'(k), 1'b0, rv_exec_pkg::EXT_NONE,
                        a_set[p], b_set[p], waited);
            end
        end
    endtask

    task automatic divide_cases();
        rv_exec_pkg::xlen_t   a_set [5];
        rv_exec_pkg::xlen_t   b_set [5];
        logic                 w_set [5];
        rv_exec_pkg::alu_op_t op;
        int                   waited;
        a_set = '{64'd100, 64'hffff_ffff_ffff_fff0, 64'd12345,
                  64'h1234_5678_9abc_def0, 64'h0000_0007_8000_0001};
        b_set = '{64'd7, 64'd3, 64'd0, 64'h0000_0001_0000_0010, 64'h0000_0005_0000_0000};
        w_set = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};  // last one divides by a zero low word
        for (int k = 0; k < 2; k++) begin
            op = (k == 0) ? rv_exec_pkg::OP_DIVU : rv_exec_pkg::OP_REMU;
            for (int p = 0; p < 5; p++) begin
                run_one($sformatf("div op%0d case%0d", op, p), op, w_set[p],
                        rv_exec_pkg::EXT_NONE, a_set[p], b_set[p], waited);
                if (waited < rv_exec_pkg::DIV_STEPS) begin
                    abort_run("divide result returned before the divider could finish");
                end
            end
        end
    endtask

    task automatic order_under_backpressure();
        rv_exec_pkg::alu_op_t ops [5];
        rv_exec_pkg::xlen_t   a_set [5];
        rv_exec_pkg::xlen_t   b_set [5];
        rv_exec_pkg::xlen_t   value;
        logic                 flag;
        int                   waited;
        ops = '{rv_exec_pkg::OP_DIVU, rv_exec_pkg::OP_ADD, rv_exec_pkg::OP_ADD,
                rv_exec_pkg::OP_ADD, rv_exec_pkg::OP_SUB};
        for (int i = 0; i < 5; i++) begin
            a_set[i] = 64'd1000 + 64'(i * 17);
            b_set[i] = 64'd3 + 64'(i);
        end
        for (int i = 0; i < 4; i++) begin
            send_op(ops[i], 1'b0, rv_exec_pkg::EXT_NONE, a_set[i], b_set[i]);
        end
        raise_op(ops[4], 1'b0, rv_exec_pkg::EXT_NONE, a_set[4], b_set[4]);
        repeat (100) begin
            @(posedge clk);
            if (op_ack) abort_run("op_ack rose while every lane was still busy");
        end
        for (int i = 0; i < 4; i++) begin
            take_result(value, flag, waited);
            check_value($sformatf("order %0d", i),
                        ref_value(ops[i], 1'b0, rv_exec_pkg::EXT_NONE, a_set[i], b_set[i]),
                        value);
            check_flag($sformatf("order %0d", i), ref_flag(ops[i], a_set[i], b_set[i]), flag);
        end
        wait_op_ack();
        finish_op();
        take_result(value, flag, waited);
        check_value("order 4", ref_value(ops[4], 1'b0, rv_exec_pkg::EXT_NONE, a_set[4],
                    b_set[4]), value);
        check_flag("order 4", ref_flag(ops[4], a_set[4], b_set[4]), flag);
    endtask

    task automatic random_ops();
        rv_exec_pkg::alu_op_t  op;
        rv_exec_pkg::ext_sel_t ext;
        rv_exec_pkg::xlen_t    a;
        rv_exec_pkg::xlen_t    b;
        logic                  word;
        int                    waited;
        for (int i = 0; i < 200; i++) begin
            op   = rv_exec_pkg::alu_op_t'(rand_bits(5) % 20);
            word = 1'(rand_bits(1));
            ext  = rv_exec_pkg::ext_sel_t'(rand_bits(3) % 5);
            a    = rand_bits(64);
            b    = rand_bits(64);
            if (rand_bits(2) == 0) b = a;  // hit equal operands now and then
            run_one($sformatf("random %0d op%0d", i, op), op, word, ext, a, b, waited);
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        op_req  = 1'b0;
        op_code = '0;
        word_op = 1'b0;
        ext_sel = '0;
        src1    = '0;
        src2    = '0;
        res_ack = 1'b0;
        lfsr    = 16'd55300;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (op_ack || res_req) abort_run("handshake outputs high after reset");
        exercise_alu_ops();
        sweep_shifts();
        compare_branches();
        divide_cases();
        order_under_backpressure();
        random_ops();
        $display("sim passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
src/rv_exec_pkg.sv
src/alu_issue_dispatch.sv
src/alu_lane.sv
src/result_reorder.sv
src/alu_cluster_top.sv
tests/tb_alu_cluster.sv

/* Bender.yml */
package:
  name: rv_exec_cluster

sources:
  - src/rv_exec_pkg.sv
  - src/alu_issue_dispatch.sv
  - src/alu_lane.sv
  - src/result_reorder.sv
  - src/alu_cluster_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_alu_cluster.sv
